//--- vlog.f
hw/ramio_pkg.sv
hw/cache.sv
hw/io_port.sv
hw/ramio.sv
sim/burst_ram_model.sv
sim/ramio_tb.sv

//--- Makefile
# verilator build and run for the ramio front end
# pass or fail is taken from the simulation log

VERILATOR ?= verilator
TOP       ?= ramio_tb
FLIST     ?= vlog.f
LOG       ?= sim.log
VFLAGS    ?= --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/ramio_tb.sv
/*
  ramio testbench
  random loads and stores against a byte reference memory,
  cache hit timing, write-back line contents, led and uart
*/
`timescale 1ns/10ps
`default_nettype none

module ramio_tb
  import ramio_pkg::*;
();

  localparam int          N_RANDOM  = 400;
  localparam int          TIMEOUT   = 400;   // cycles per access
  localparam int          RX_WAIT   = 2000;  // cycles for uart frames
  localparam logic [31:0] LED_ADDR  = IO_BASE + 32'd8;
  localparam logic [31:0] UART_ADDR = IO_BASE + 32'd12;

  typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

  logic                     clk;
  logic                     rst;
  logic                     enable;
  read_type_e               read_type;
  write_type_e              write_type;
  logic [31:0]              address;
  logic [31:0]              data_in;
  logic [31:0]              data_out;
  logic                     data_out_ready;
  logic                     busy;
  logic [3:0]               led;
  logic                     uart_tx;
  logic                     br_cmd;
  logic                     br_cmd_en;
  logic [RAM_ADDR_BITS-1:0] br_addr;
  br_line_t                 br_wr_data;
  br_line_t                 br_rd_data;
  logic                     br_rd_data_valid;

  integer     seed;
  int         errors;
  int         accesses;
  logic [7:0] ref_mem [ram_addr_t];  // reference bytes that default to 0
  logic [7:0] rx_q [$];              // bytes seen on uart_tx

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ramio dut_i (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .read_type        (read_type),
    .write_type       (write_type),
    .address          (address),
    .data_in          (data_in),
    .data_out         (data_out),
    .data_out_ready   (data_out_ready),
    .busy             (busy),
    .led              (led),
    .uart_tx          (uart_tx),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  burst_ram_model ram_i (
    .clk              (clk),
    .rst              (rst),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [7:0] mem_byte(input ram_addr_t a);
    if (ref_mem.exists(a)) return ref_mem[a];
    return 8'h00;
  endfunction

  // core lanes hold a byte in 7:0 and a half in 15:0
  task automatic apply_store(input write_type_e wt, input ram_addr_t a, input logic [31:0] d);
    int n;
    n = (wt == wt_byte) ? 1 : (wt == wt_half) ? 2 : 4;
    for (int i = 0; i < n; i++) ref_mem[a + ram_addr_t'(i)] = d[i*8 +: 8];
  endtask

  function automatic logic [31:0] expected_load(input read_type_e rt, input ram_addr_t a);
    logic [31:0] w;
    w = {mem_byte(a + ram_addr_t'(3)), mem_byte(a + ram_addr_t'(2)),
         mem_byte(a + ram_addr_t'(1)), mem_byte(a)};
    case (rt)
      rt_byte:   return {{24{w[7]}}, w[7:0]};   // sign extend
      rt_half:   return {{16{w[15]}}, w[15:0]};
      rt_byte_u: return {24'd0, w[7:0]};
      rt_half_u: return {16'd0, w[15:0]};
      default:   return w;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    errors++;
    $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
  endtask

  task automatic check_idle();
    if (busy !== 1'b0) report_mismatch("reset busy", 64'd0, 64'(busy));
    if (data_out_ready !== 1'b0) begin
      report_mismatch("reset data_out_ready", 64'd0, 64'(data_out_ready));
    end
    if (br_cmd_en !== 1'b0) report_mismatch("reset br_cmd_en", 64'd0, 64'(br_cmd_en));
    if (uart_tx !== 1'b1) report_mismatch("reset uart_tx", 64'd1, 64'(uart_tx));
    if (led !== 4'd0) report_mismatch("reset led", 64'd0, 64'(led));
  endtask

  // --------------------------------------------------
  // one core access that ends when busy falls
  // --------------------------------------------------
  task automatic access(input read_type_e rt, input write_type_e wt, input logic [31:0] addr,
                        input logic [31:0] wdata, output logic [31:0] rdata,
                        output int edges);
    bit got_ready;
    accesses++;
    @(posedge clk);
    enable     <= 1'b1;
    read_type  <= rt;
    write_type <= wt;
    address    <= addr;
    data_in    <= wdata;
    @(posedge clk);  // enable taken here
    enable     <= 1'b0;
    read_type  <= rt_none;
    write_type <= wt_none;
    @(negedge clk);
    if (busy !== 1'b1) begin
      errors++;
      $display("busy did not rise after enable, address %h", addr);
    end
    edges     = 0;
    got_ready = 1'b0;
    rdata     = '0;
    while (busy === 1'b1 && edges < TIMEOUT) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      if (data_out_ready === 1'b1) begin
        if (busy === 1'b1) begin
          errors++;
          $display("data_out_ready came while busy was still high, address %h", addr);
        end
        got_ready = 1'b1;
        rdata     = data_out;
      end
    end
    if (busy === 1'b1) begin
      errors++;
      $display("timeout, access to %h still busy after %0d cycles", addr, TIMEOUT);
    end else if (rt != rt_none && !got_ready) begin
      errors++;
      $display("load from %h ended without data_out_ready", addr);
    end else if (rt == rt_none && got_ready) begin
      errors++;
      $display("store to %h gave a data_out_ready pulse", addr);
    end
  endtask

  // --------------------------------------------------
  // monitors
  // --------------------------------------------------
  // evicted line must match the reference at br_addr
  always @(negedge clk) begin : wb_check
    br_line_t exp_line;
    if (rst === 1'b0 && br_cmd_en === 1'b1 && br_cmd === 1'b1) begin
      for (int b = 0; b < 8; b++) exp_line[b*8 +: 8] = mem_byte(br_addr + ram_addr_t'(b));
      if (br_addr[2:0] !== 3'd0) begin
        report_mismatch("write-back alignment", 64'd0, 64'(br_addr[2:0]));
      end
      if (br_wr_data !== exp_line) report_mismatch("write-back line", exp_line, br_wr_data);
    end
  end

  // uart receiver sampling mid bit
  initial begin : uart_rx
    logic [7:0] rx_byte;
    forever begin
      @(negedge clk);
      if (rst === 1'b0 && uart_tx === 1'b0) begin
        repeat (CLOCKS_PER_BIT / 2 - 1) @(negedge clk);
        if (uart_tx !== 1'b0) begin
          errors++;
          $display("uart start bit did not stay low to its middle");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (CLOCKS_PER_BIT) @(negedge clk);
          rx_byte[i] = uart_tx;  // lsb first
        end
        repeat (CLOCKS_PER_BIT) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          errors++;
          $display("uart stop bit missing after byte %h", rx_byte);
        end
        rx_q.push_back(rx_byte);
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : main
    logic [31:0]         r;
    logic [31:0]         d;
    logic [31:0]         addr;
    logic [31:0]         got;
    logic [31:0]         got2;
    logic [31:0]         expv;
    logic [TAG_BITS-1:0] tag;
    logic [1:0]          off;
    logic [7:0]          sent [3];
    ram_addr_t           ra;
    read_type_e          rt;
    write_type_e         wt;
    int                  edges;
    int                  k;
    int                  w;

    seed       = 32'hdece0011;
    errors     = 0;
    accesses   = 0;
    rst        <= 1'b1;
    enable     <= 1'b0;
    read_type  <= rt_none;
    write_type <= wt_none;
    address    <= '0;
    data_in    <= '0;

    // reset held over 3 edges with idle checked during and after
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      if (i == 2) rst <= 1'b0;
      @(negedge clk);
      check_idle();
    end

    // random ram traffic over 4 tags so lines conflict
    for (int n = 0; n < N_RANDOM; n++) begin
      r   = $random(seed);
      d   = $random(seed);
      tag = {r[1:0], 10'h155};
      off = r[10:9];
      if (r[21]) begin
        k  = r[24:22] % 5;
        rt = read_type_e'(3'(k + 1));
        if (rt == rt_half || rt == rt_half_u) off[0] = 1'b0;
        if (rt == rt_word) off = 2'b00;
        ra   = {tag, r[7:2], r[8], off};
        addr = {1'b0, r[20:11], ra};  // upper bits wrap onto ram
        access(rt, wt_none, addr, d, got, edges);
        expv = expected_load(rt, ra);
        if (got !== expv) report_mismatch("random load", 64'(expv), 64'(got));
        if (r[26:25] == 2'b00) begin
          access(rt, wt_none, addr, d, got2, edges);  // line is resident now
          if (edges != 2) report_mismatch("hit latency", 64'd2, 64'(edges));
          if (got2 !== expv) report_mismatch("repeat load", 64'(expv), 64'(got2));
        end
      end else begin
        k  = r[23:22] % 3;
        wt = write_type_e'(2'(k + 1));
        if (wt == wt_half) off[0] = 1'b0;
        if (wt == wt_word) off = 2'b00;
        ra   = {tag, r[7:2], r[8], off};
        addr = {1'b0, r[20:11], ra};
        apply_store(wt, ra, d);  // reference updated at issue
        access(rt_none, wt, addr, d, got, edges);
      end
    end

    // led register
    for (int i = 0; i < 3; i++) begin
      d = $random(seed);
      access(rt_none, wt_byte, LED_ADDR, d, got, edges);
      if (led !== d[3:0]) report_mismatch("led store", 64'(d[3:0]), 64'(led));
      access(rt_word, wt_none, LED_ADDR, 32'd0, got, edges);
      if (got !== {28'd0, d[3:0]}) report_mismatch("led load", 64'(d[3:0]), 64'(got));
    end

    // back-to-back uart bytes then the busy flag
    for (int i = 0; i < 3; i++) begin
      d       = $random(seed);
      sent[i] = d[7:0];
      access(rt_none, wt_byte, UART_ADDR, d, got, edges);
    end
    access(rt_word, wt_none, UART_ADDR, 32'd0, got, edges);
    if (got !== 32'd1) report_mismatch("uart busy flag", 64'd1, 64'(got));
    w = 0;
    while (rx_q.size() < 3 && w < RX_WAIT) begin
      @(negedge clk);
      w++;
    end
    if (rx_q.size() < 3) begin
      errors++;
      $display("timeout, only %0d of 3 uart bytes received", rx_q.size());
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (rx_q[i] !== sent[i]) report_mismatch("uart byte", 64'(sent[i]), 64'(rx_q[i]));
      end
    end

    $display("accesses: %0d  errors: %0d", accesses, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/burst_ram_model.sv
/*
  burst ram model
  behavioral psram controller, one command at a time,
  reads answer after 2 to 9 cycles, writes land at once
*/
`timescale 1ns/10ps
`default_nettype none

module burst_ram_model
  import ramio_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      br_cmd,        // 0 read, 1 write
  input  wire                      br_cmd_en,
  input  wire [RAM_ADDR_BITS-1:0]  br_addr,
  input  wire br_line_t            br_wr_data,
  output br_line_t                 br_rd_data,
  output logic                     br_rd_data_valid
);

  logic [7:0]               mem [logic [RAM_ADDR_BITS-1:0]];  // unwritten bytes read 0
  logic                     pending;
  int                       wait_cnt;
  logic [RAM_ADDR_BITS-1:0] rd_addr;
  integer                   seed;

  initial seed = 32'hdece0011;

  function automatic br_line_t read_line(input logic [RAM_ADDR_BITS-1:0] a);
    br_line_t                 l;
    logic [RAM_ADDR_BITS-1:0] k;
    for (int b = 0; b < 8; b++) begin
      k = a + RAM_ADDR_BITS'(b);
      l[b*8 +: 8] = mem.exists(k) ? mem[k] : 8'h00;
    end
    return l;
  endfunction

  always @(posedge clk) begin
    br_rd_data_valid <= 1'b0;  // one cycle pulse
    if (rst) begin
      pending <= 1'b0;
    end else if (br_cmd_en && br_cmd) begin
      for (int b = 0; b < 8; b++) begin
        mem[br_addr + RAM_ADDR_BITS'(b)] = br_wr_data[b*8 +: 8];
      end
    end else if (br_cmd_en) begin
      pending  <= 1'b1;
      wait_cnt <= 2 + ($unsigned($random(seed)) % 8);  // read latency
      rd_addr  <= br_addr;
    end else if (pending) begin
      if (wait_cnt <= 1) begin
        pending          <= 1'b0;
        br_rd_data_valid <= 1'b1;
        br_rd_data       <= read_line(rd_addr);
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/ramio.sv
/*
  ramio front end
  takes one core load or store, routes it to the line cache or
  the io port, and returns aligned, extended load data
*/
`timescale 1ns/10ps
`default_nettype none

module ramio
  import ramio_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,

  // core side
  input  wire                      enable,          // taken while !busy
  input  wire read_type_e          read_type,
  input  wire write_type_e         write_type,
  input  wire [31:0]               address,
  input  wire [31:0]               data_in,
  output logic [31:0]              data_out,
  output logic                     data_out_ready,  // loads only
  output logic                     busy,

  output logic [3:0]               led,
  output logic                     uart_tx,

  // burst ram
  output logic                     br_cmd,
  output logic                     br_cmd_en,
  output logic [RAM_ADDR_BITS-1:0] br_addr,
  output br_line_t                 br_wr_data,
  input  wire br_line_t            br_rd_data,
  input  wire                      br_rd_data_valid
);

  logic        accept;
  logic        is_io;
  logic        cache_req;
  logic        io_req;
  word_req_t   wreq;
  io_req_t     ioreq;
  logic        cache_done;
  logic        io_done;
  logic [31:0] cache_rdata;
  logic [7:0]  io_rdata;
  logic        done;

  read_type_e  acc_rt;    // latched access
  logic [1:0]  acc_off;
  logic        acc_io;

  logic [3:0]  st_mask;
  logic [31:0] st_data;
  logic [31:0] ret_word;
  logic [31:0] ret_shift;
  logic [31:0] load_val;

  assign accept = enable && !busy;
  assign is_io  = (address >= IO_BASE);
  assign done   = acc_io ? io_done : cache_done;

  // --------------------------------------------------
  // store lane placement
  // --------------------------------------------------
  always_comb begin
    case (write_type)
      wt_byte: begin
        st_mask = 4'b0001 << address[1:0];
        st_data = {4{data_in[7:0]}};
      end
      wt_half: begin
        st_mask = address[1] ? 4'b1100 : 4'b0011;
        st_data = {2{data_in[15:0]}};
      end
      wt_word: begin
        st_mask = 4'b1111;
        st_data = data_in;
      end
      default: begin
        st_mask = 4'b0000;  // load
        st_data = data_in;
      end
    endcase
  end

  // --------------------------------------------------
  // load extraction
  // --------------------------------------------------
  always_comb begin
    ret_word  = acc_io ? {24'd0, io_rdata} : cache_rdata;
    ret_shift = ret_word >> {acc_off, 3'b000};  // addressed lane to bit 0
    case (acc_rt)
      rt_byte:   load_val = {{24{ret_shift[7]}}, ret_shift[7:0]};
      rt_half:   load_val = {{16{ret_shift[15]}}, ret_shift[15:0]};
      rt_byte_u: load_val = {24'd0, ret_shift[7:0]};
      rt_half_u: load_val = {16'd0, ret_shift[15:0]};
      default:   load_val = ret_word;  // word
    endcase
  end

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      busy           <= 1'b0;
      data_out_ready <= 1'b0;
      cache_req      <= 1'b0;
      io_req         <= 1'b0;
    end else begin
      cache_req      <= accept && !is_io;  // one cycle each
      io_req         <= accept && is_io;
      data_out_ready <= busy && done && (acc_rt != rt_none);
      if (accept) busy <= 1'b1;
      else if (done) busy <= 1'b0;  // same edge as ready
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      acc_rt        <= read_type;
      acc_off       <= address[1:0];
      acc_io        <= is_io;
      wreq.write    <= (write_type != wt_none);
      wreq.addr     <= address[RAM_ADDR_BITS-1:2];  // wraps ram space
      wreq.mask     <= st_mask;
      wreq.data     <= st_data;
      ioreq.write   <= (write_type != wt_none);
      ioreq.reg_sel <= io_reg_e'(address[2]);
      ioreq.data    <= data_in[7:0];
    end
    if (done) data_out <= load_val;
  end

  cache cache_i (
    .clk              (clk),
    .rst              (rst),
    .req              (cache_req),
    .wreq             (wreq),
    .done             (cache_done),
    .rdata            (cache_rdata),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  io_port io_port_i (
    .clk      (clk),
    .rst      (rst),
    .req      (io_req),
    .ioreq    (ioreq),
    .done     (io_done),
    .rdata_io (io_rdata),
    .led      (led),
    .uart_tx  (uart_tx)
  );

endmodule

`default_nettype wire

//--- hw/io_port.sv
/*
  io port
  4 bit led register and a uart transmitter (8N1),
  with readback of the led value and the tx busy flag
*/
`timescale 1ns/10ps
`default_nettype none

module io_port
  import ramio_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire          req,       // one cycle strobe
  input  wire io_req_t ioreq,
  output logic         done,
  output logic [7:0]   rdata_io,
  output logic [3:0]   led,
  output logic         uart_tx    // idles high
);

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  tx_state_e                tx_state;
  logic [BAUD_CNT_BITS-1:0] baud_cnt;
  logic [2:0]               bit_idx;
  logic [7:0]               shift;      // data bits, lsb goes first
  logic                     pend;       // uart write waiting for tx
  logic [7:0]               pend_byte;
  logic [7:0]               tx_byte;
  logic                     uart_wr;
  logic                     tx_load;
  logic                     tx_busy;
  logic                     bit_end;

  assign tx_busy = (tx_state != tx_idle);
  assign uart_wr = req && ioreq.write && (ioreq.reg_sel == io_uart);
  assign tx_load = (uart_wr || pend) && !tx_busy;  // only ever one of the two
  assign tx_byte = pend ? pend_byte : ioreq.data;
  assign bit_end = (baud_cnt == BAUD_CNT_BITS'(CLOCKS_PER_BIT - 1));

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
      led  <= 4'd0;
      pend <= 1'b0;
    end else begin
      // uart write answers when the byte is taken
      done <= (req && !uart_wr) || tx_load;
      if (req && ioreq.write && ioreq.reg_sel == io_led) begin
        led <= ioreq.data[3:0];
      end
      if (tx_load) pend <= 1'b0;
      else if (uart_wr) pend <= 1'b1;  // tx still busy
    end
  end

  always_ff @(posedge clk) begin
    if (uart_wr) pend_byte <= ioreq.data;
    if (req) begin
      rdata_io <= (ioreq.reg_sel == io_led) ? {4'd0, led} : {7'd0, tx_busy};
    end
  end

  // --------------------------------------------------
  // transmitter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_state <= tx_idle;
      uart_tx  <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= 3'd0;
    end else begin
      baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
      case (tx_state)
        tx_idle: begin
          baud_cnt <= '0;  // bit timing starts at load
          if (tx_load) begin
            tx_state <= tx_start;
            uart_tx  <= 1'b0;
          end
        end
        tx_start: begin
          if (bit_end) begin
            tx_state <= tx_data;
            uart_tx  <= shift[0];
            bit_idx  <= 3'd0;
          end
        end
        tx_data: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              tx_state <= tx_stop;
              uart_tx  <= 1'b1;
            end else begin
              uart_tx <= shift[0];
              bit_idx <= bit_idx + 3'd1;
            end
          end
        end
        tx_stop: begin
          if (bit_end) tx_state <= tx_idle;
        end
        default: tx_state <= tx_idle;
      endcase
    end
  end

  // next bit sits in shift[0] at every bit boundary
  always_ff @(posedge clk) begin
    if (tx_load) shift <= tx_byte;
    else if (bit_end && (tx_state == tx_start || tx_state == tx_data)) shift <= shift >> 1;
  end

endmodule

`default_nettype wire

//--- hw/cache.sv
/*
  line cache
  direct mapped, write back, write allocate; 64 lines of 8 bytes
  sitting in front of the burst psram controller
*/
`timescale 1ns/10ps
`default_nettype none

module cache
  import ramio_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,

  // word request from the front end
  input  wire                      req,          // one cycle strobe
  input  wire word_req_t           wreq,
  output logic                     done,         // hit in lookup
  output logic [31:0]              rdata,        // whole word

  // burst ram
  output logic                     br_cmd,       // 0 read, 1 write
  output logic                     br_cmd_en,
  output logic [RAM_ADDR_BITS-1:0] br_addr,      // line byte address
  output br_line_t                 br_wr_data,
  input  wire br_line_t            br_rd_data,
  input  wire                      br_rd_data_valid
);

  typedef enum logic [1:0] {
    idle,
    lookup,
    write_back,
    fill
  } state_e;

  state_e state;

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  logic [TAG_BITS-1:0]   tag_mem [LINE_COUNT];
  br_line_t              data_mem [LINE_COUNT];
  logic [LINE_COUNT-1:0] valid;
  logic [LINE_COUNT-1:0] dirty;

  word_req_t                  req_r;     // access being served
  logic [LINE_INDEX_BITS-1:0] idx;
  logic [TAG_BITS-1:0]        tag;
  logic                       word_sel;  // upper or lower word of line
  br_line_t                   line;
  logic                       hit;
  logic                       victim;    // line must go back first
  logic                       fill_in;

  // word address split: tag | index | word select
  assign word_sel = req_r.addr[0];
  assign idx      = req_r.addr[LINE_INDEX_BITS:1];
  assign tag      = req_r.addr[RAM_ADDR_BITS-3:LINE_INDEX_BITS+1];

  assign line    = data_mem[idx];
  assign hit     = valid[idx] && (tag_mem[idx] == tag);
  assign victim  = valid[idx] && dirty[idx];
  assign fill_in = (state == fill) && br_rd_data_valid;

  // answer straight out of lookup, keeps a hit at 2 cycles
  assign done  = (state == lookup) && hit;
  assign rdata = word_sel ? line[63:32] : line[31:0];

  // store bytes under the mask into one word of the line
  function automatic br_line_t merge_word(
    input br_line_t    old_line,
    input logic        sel,
    input logic [3:0]  mask,
    input logic [31:0] data
  );
    br_line_t res;
    res = old_line;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[(sel * 4 + b) * 8 +: 8] = data[b * 8 +: 8];
      end
    end
    return res;
  endfunction

  // --------------------------------------------------
  // control fsm
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      valid     <= '0;
      dirty     <= '0;
      br_cmd_en <= 1'b0;
      br_cmd    <= 1'b0;
    end else begin
      br_cmd_en <= 1'b0;  // strobe
      case (state)
        idle: begin
          if (req) state <= lookup;
        end
        lookup: begin
          if (hit) begin
            state <= idle;
            if (req_r.write) dirty[idx] <= 1'b1;  // line now differs from ram
          end else if (victim) begin
            // evict first, fill follows
            br_cmd_en <= 1'b1;
            br_cmd    <= 1'b1;
            state     <= write_back;
          end else begin
            br_cmd_en <= 1'b1;  // clean miss, read right away
            br_cmd    <= 1'b0;
            state     <= fill;
          end
        end
        write_back: begin
          // write went out last cycle, no ack to wait for
          br_cmd_en <= 1'b1;
          br_cmd    <= 1'b0;
          state     <= fill;
        end
        fill: begin
          if (br_rd_data_valid) begin
            valid[idx] <= 1'b1;
            dirty[idx] <= 1'b0;
            state      <= lookup;  // replay as a hit
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // --------------------------------------------------
  // data path, line store and burst payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == idle && req) req_r <= wreq;

    if (done && req_r.write) begin
      data_mem[idx] <= merge_word(line, word_sel, req_r.mask, req_r.data);
    end

    if (fill_in) begin
      data_mem[idx] <= br_rd_data;
      tag_mem[idx]  <= tag;
    end

    if (state == lookup && !hit) begin
      // victim address when dirty, else the missing line
      br_addr    <= victim ? {tag_mem[idx], idx, 3'b000} : {tag, idx, 3'b000};
      br_wr_data <= line;
    end

    if (state == write_back) br_addr <= {tag, idx, 3'b000};
  end

endmodule

`default_nettype wire

//--- hw/ramio_pkg.sv
/*
  ramio shared definitions
  address map, access types and the request records that
  pass between the front end, the line cache and the io port
*/
`default_nettype none

package ramio_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int RAM_ADDR_BITS   = 21;  // psram byte address
  localparam int LINE_INDEX_BITS = 6;   // 64 lines of 8 bytes
  localparam int CLOCKS_PER_BIT  = 8;   // short bit time for sim

  // derived from the above
  localparam int LINE_COUNT    = 1 << LINE_INDEX_BITS;
  localparam int TAG_BITS      = RAM_ADDR_BITS - 3 - LINE_INDEX_BITS;
  localparam int BAUD_CNT_BITS = $clog2(CLOCKS_PER_BIT);

  localparam logic [31:0] IO_BASE = 32'hFFFF_FFF0;  // io window start

  // --------------------------------------------------
  // access encodings, as driven by the core
  // --------------------------------------------------
  typedef enum logic [2:0] {
    rt_none   = 3'd0,
    rt_byte   = 3'd1,
    rt_half   = 3'd2,
    rt_word   = 3'd3,
    rt_byte_u = 3'd4,
    rt_half_u = 3'd5
  } read_type_e;

  typedef enum logic [1:0] {
    wt_none = 2'd0,
    wt_byte = 2'd1,
    wt_half = 2'd2,
    wt_word = 2'd3
  } write_type_e;

  // address bit 2 inside the io window
  typedef enum logic {
    io_led  = 1'b0,  // IO_BASE + 8
    io_uart = 1'b1   // IO_BASE + 12
  } io_reg_e;

  typedef struct packed {
    logic                     write;
    logic [RAM_ADDR_BITS-3:0] addr;   // word address
    logic [3:0]               mask;   // byte enables
    logic [31:0]              data;   // already on its lanes
  } word_req_t;

  typedef struct packed {
    logic    write;
    io_reg_e reg_sel;
    logic [7:0] data;
  } io_req_t;

  typedef logic [63:0] br_line_t;  // byte 0 in bits 7:0

endpackage

`default_nettype wire
